// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = execUnitTb
FILELIST = vlog.f
OBJDIR   = obj_dir
LOG      = sim.log
FAILMSG  = Something failed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAILMSG)" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: bench/execChecker.sv
`timescale 1ns/1ps
`include "exec_macros.svh"

module execChecker import execPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    input  logic                 inReady,
    input  logic [`OPCODE_W-1:0] opcode,
    input  logic [`FUNCT3_W-1:0] funct3,
    input  logic                 bit30,
    input  logic [`XLEN-1:0]     rs1Val,
    input  logic [`XLEN-1:0]     rs2Val,
    input  logic [`XLEN-1:0]     imm,
    input  logic [`XLEN-1:0]     pc,
    input  logic                 outValid,
    input  logic                 outReady,
    input  logic [`XLEN-1:0]     result,
    input  logic                 branchTaken,
    input  logic [`XLEN-1:0]     target,
    input  logic                 illegal,
    output int                   mismatchCount,
    output int                   protocolErrors,
    output int                   acceptedCount,
    output int                   consumedCount
);

    logic [2*`XLEN+1:0] expQ[$];    // {illegal, taken, target, result} per accepted instruction
    logic [2*`XLEN+1:0] expected;
    bit                 started;

    // ====================
    // reference model
    // ====================

    // works on the input fields as they stand at the sampling edge
    function automatic logic [2*`XLEN+1:0] predict();
        logic [`XLEN-1:0] opB;
        logic [`XLEN-1:0] res;
        logic [`XLEN-1:0] tgt;
        logic             tk;
        logic             ill;
        logic             lt;
        logic             ltu;
        opB = (opcode == opReg || opcode == opBranch) ? rs2Val : imm;
        lt  = $signed(rs1Val) < $signed(opB);
        ltu = rs1Val < opB;
        res = rs1Val + opB;                              // unknown opcodes still add
        tgt = '0;
        tk  = 1'b0;
        ill = 1'b0;
        case (opcode)
            opReg, opImm: begin
                case (funct3)
                    3'b000: res = (opcode == opReg && bit30) ? rs1Val - opB : rs1Val + opB;
                    3'b001: res = rs1Val << opB[4:0];
                    3'b010: res = `XLEN'(lt);
                    3'b011: res = `XLEN'(ltu);
                    3'b100: res = rs1Val ^ opB;
                    3'b101: res = bit30 ? $unsigned($signed(rs1Val) >>> opB[4:0])
                                        : rs1Val >> opB[4:0];
                    3'b110: res = rs1Val | opB;
                    default: res = rs1Val & opB;
                endcase
            end
            opLoad, opStore: res = rs1Val + imm;
            opLui:           res = imm;
            opAuipc:         res = pc + imm;
            opJal, opJalr: begin
                res = pc + 4;                            // link value
                tk  = 1'b1;
                tgt = (opcode == opJal) ? pc + imm : (rs1Val + imm) & ~`XLEN'd1;
            end
            opBranch: begin
                tgt = pc + imm;
                case (funct3)
                    3'b000: {tk, res} = {rs1Val == rs2Val, rs1Val - rs2Val};
                    3'b001: {tk, res} = {rs1Val != rs2Val, rs1Val - rs2Val};
                    3'b100: {tk, res} = {lt, `XLEN'(lt)};
                    3'b101: {tk, res} = {!lt, `XLEN'(!lt)};
                    3'b110: {tk, res} = {ltu, `XLEN'(ltu)};
                    3'b111: {tk, res} = {!ltu, `XLEN'(!ltu)};
                    default: ill = 1'b1;                 // no branch has funct3 010 or 011
                endcase
            end
            default: ill = 1'b1;
        endcase
        return {ill, tk, tgt, res};
    endfunction

    task automatic checkField(input string name, input logic [`XLEN-1:0] expVal,
                              input logic [`XLEN-1:0] gotVal);
        if (gotVal !== expVal) begin
            mismatchCount++;
            $display("MISMATCH %s at %0t: expected %h, got %h", name, $time, expVal, gotVal);
        end
    endtask

    // ====================
    // transfer tracking
    // ====================

    always @(posedge clk) begin
        if (rstN) begin
            if (!started) begin
                checkField("outValid", '0, `XLEN'(outValid));   // idle state after reset
                checkField("inReady", `XLEN'd1, `XLEN'(inReady));
            end
            if (outValid && outReady) begin              // consume before the refill of this edge
                if (expQ.size() == 0) begin
                    protocolErrors++;
                    $display("result delivered at %0t with no instruction pending", $time);
                end else begin
                    expected = expQ.pop_front();
                    consumedCount++;
                    checkField("result", expected[`XLEN-1:0], result);
                    checkField("target", expected[2*`XLEN-1:`XLEN], target);
                    checkField("branchTaken", `XLEN'(expected[2*`XLEN]), `XLEN'(branchTaken));
                    checkField("illegal", `XLEN'(expected[2*`XLEN+1]), `XLEN'(illegal));
                end
            end
            if (inValid && inReady) begin
                expQ.push_back(predict());
                acceptedCount++;
                started = 1'b1;
            end
        end
    end

endmodule

// File: bench/execUnitTb.sv
`timescale 1ns/1ps
`include "exec_macros.svh"

module execUnitTb import execPkg::*; ();

    localparam int clkPeriod   = 4;
    localparam int resetCycles = 10;
    localparam int numInstr    = 2000;
    localparam int drainLimit  = 16;
    localparam int timeoutNs   = (resetCycles + numInstr * 4) * clkPeriod;

    logic                 clk;
    logic                 rstN;
    logic                 inValid;
    logic                 inReady;
    logic [`OPCODE_W-1:0] opcode;
    logic [`FUNCT3_W-1:0] funct3;
    logic                 bit30;
    logic [`XLEN-1:0]     rs1Val;
    logic [`XLEN-1:0]     rs2Val;
    logic [`XLEN-1:0]     imm;
    logic [`XLEN-1:0]     pc;
    logic                 outValid;
    logic                 outReady;
    logic [`XLEN-1:0]     result;
    logic                 branchTaken;
    logic [`XLEN-1:0]     target;
    logic                 illegal;
    int                   mismatchCount;
    int                   protocolErrors;
    int                   acceptedCount;
    int                   consumedCount;
    int                   endErrors;

    execUnit dut0 (.*);
    execChecker chk0 (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(timeoutNs);
        $display("timeout: run still busy after %0d ns", timeoutNs);
        $display("Something failed");
        $finish;
    end

    // ====================
    // stimulus
    // ====================

    task automatic randomizeInstr();
        logic [11:0] imm12;
        case ($urandom_range(0, 17))
            0, 1, 2:        opcode = opReg;
            3, 4, 5:        opcode = opImm;
            6:              opcode = opLoad;
            7:              opcode = opStore;
            8:              opcode = opLui;
            9:              opcode = opAuipc;
            10, 11, 12, 13: opcode = opBranch;
            14:             opcode = opJal;
            15:             opcode = opJalr;
            default: begin
                do begin
                    opcode = `OPCODE_W'($urandom());
                end while (opcode inside {opLoad, opImm, opAuipc, opStore, opReg,
                                          opLui, opBranch, opJalr, opJal});
            end
        endcase
        funct3 = `FUNCT3_W'($urandom());
        bit30  = 1'($urandom());
        rs1Val = $urandom();
        rs2Val = ($urandom_range(0, 3) == 0) ? rs1Val : $urandom();  // equal operands now and then
        imm12  = 12'($urandom());
        if (opcode == opLui || opcode == opAuipc) begin
            imm = {20'($urandom()), 12'h000};
        end else begin
            imm = {{20{imm12[11]}}, imm12};
        end
        pc = $urandom() & ~`XLEN'd3;
    endtask

    initial begin
        int sent;
        bit willFire;
        int drainWait;
        void'($urandom(32'hccd3));
        rstN     = 1'b0;
        inValid  = 1'b0;
        outReady = 1'b0;
        opcode   = '0;
        funct3   = '0;
        bit30    = 1'b0;
        rs1Val   = '0;
        rs2Val   = '0;
        imm      = '0;
        pc       = '0;
        sent     = 0;
        willFire = 1'b0;
        drainWait = 0;
        endErrors = 0;
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
        while (sent < numInstr) begin
            @(posedge clk);
            if (willFire) sent++;
            #1;
            outReady = ($urandom_range(0, 2) != 0);
            if (willFire || !inValid) begin           // fields change only once taken
                if (sent < numInstr && $urandom_range(0, 3) != 0) begin
                    randomizeInstr();
                    inValid = 1'b1;
                end else begin
                    inValid = 1'b0;
                end
            end
            #1;
            willFire = inValid && inReady;             // handshake level, settled before the edge
        end
        while (consumedCount < acceptedCount && drainWait < drainLimit) begin
            @(posedge clk);
            #1;
            outReady = 1'b1;
            drainWait++;
        end
        repeat (4) @(posedge clk);
        if (consumedCount != acceptedCount) begin
            endErrors++;
            $display("%0d instructions accepted but only %0d results taken",
                     acceptedCount, consumedCount);
        end
        $display("errors: %0d mismatches, %0d protocol, %0d end of run",
                 mismatchCount, protocolErrors, endErrors);
        if (mismatchCount + protocolErrors + endErrors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: include/exec_macros.svh
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// ====================
// datapath widths
// ====================

`define XLEN 32         // data and address width

// ====================
// instruction fields
// ====================

`define OPCODE_W 7      // major opcode field
`define FUNCT3_W 3      // funct3 field

// ====================
// alu operation code
// ====================

`define ALUOP_W 4       // enough for every aluOpT member

`endif

// File: src/aluCore.sv
`timescale 1ns/1ps
`include "exec_macros.svh"

module aluCore import execPkg::*; (
    input  aluOpT            aluOp,
    input  logic [`XLEN-1:0] opA,
    input  logic [`XLEN-1:0] opB,
    output logic [`XLEN-1:0] aluResult,
    output logic             zero
);

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = opB[4:0];                      // only the low five bits shift
    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    always_comb begin
        case (aluOp)
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluSll:  aluResult = opA << shamt;
            aluSlt:  aluResult = {{(`XLEN-1){1'b0}}, ltSigned};
            aluSltu: aluResult = {{(`XLEN-1){1'b0}}, ltUnsigned};
            aluXor:  aluResult = opA ^ opB;
            aluSrl:  aluResult = opA >> shamt;
            aluSra:  aluResult = $unsigned($signed(opA) >>> shamt);
            aluOr:   aluResult = opA | opB;
            aluAnd:  aluResult = opA & opB;
            aluSge:  aluResult = {{(`XLEN-1){1'b0}}, ~ltSigned};
            aluSgeu: aluResult = {{(`XLEN-1){1'b0}}, ~ltUnsigned};
            default: aluResult = opA + opB;
        endcase
    end

    assign zero = (aluResult == '0);                   // equality test for beq and bne

endmodule

// File: src/aluDecoder.sv
`timescale 1ns/1ps
`include "exec_macros.svh"

module aluDecoder import execPkg::*; (
    input  logic [`OPCODE_W-1:0] opcode,
    input  logic [`FUNCT3_W-1:0] funct3,
    input  logic                 bit30,
    output aluOpT                aluOp,
    output logic                 illegal
);

    always_comb begin
        aluOp   = aluAdd;
        illegal = 1'b0;
        case (opcode)
            opReg: begin
                case (funct3)
                    3'b000: begin
                        if (bit30) begin
                            aluOp = aluSub;
                        end else begin
                            aluOp = aluAdd;
                        end
                    end
                    3'b001: aluOp = aluSll;
                    3'b010: aluOp = aluSlt;
                    3'b011: aluOp = aluSltu;
                    3'b100: aluOp = aluXor;
                    3'b101: begin
                        if (bit30) begin
                            aluOp = aluSra;
                        end else begin
                            aluOp = aluSrl;
                        end
                    end
                    3'b110: aluOp = aluOr;
                    default: aluOp = aluAnd;
                endcase
            end
            opImm: begin
                // bit 30 is part of the immediate here except for shifts
                case (funct3)
                    3'b000: aluOp = aluAdd;
                    3'b001: aluOp = aluSll;
                    3'b010: aluOp = aluSlt;
                    3'b011: aluOp = aluSltu;
                    3'b100: aluOp = aluXor;
                    3'b101: begin
                        if (bit30) begin
                            aluOp = aluSra;
                        end else begin
                            aluOp = aluSrl;
                        end
                    end
                    3'b110: aluOp = aluOr;
                    default: aluOp = aluAnd;
                endcase
            end
            opLoad, opStore, opLui, opAuipc, opJal, opJalr: begin
                aluOp = aluAdd;                     // address, upper immediate or link sum
            end
            opBranch: begin
                case (funct3)
                    3'b000, 3'b001: aluOp = aluSub;  // beq and bne look at the zero flag
                    3'b100: aluOp = aluSlt;
                    3'b101: aluOp = aluSge;
                    3'b110: aluOp = aluSltu;
                    3'b111: aluOp = aluSgeu;
                    default: begin
                        aluOp   = aluAdd;
                        illegal = 1'b1;             // funct3 010 and 011 are not branches
                    end
                endcase
            end
            default: begin
                aluOp   = aluAdd;
                illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: src/branchUnit.sv
`timescale 1ns/1ps
`include "exec_macros.svh"

module branchUnit import execPkg::*; (
    input  logic [`OPCODE_W-1:0] opcode,
    input  logic [`FUNCT3_W-1:0] funct3,
    input  logic [`XLEN-1:0]     aluResult,
    input  logic                 zero,
    input  logic [`XLEN-1:0]     rs1Val,
    input  logic [`XLEN-1:0]     imm,
    input  logic [`XLEN-1:0]     pc,
    output logic                 taken,
    output logic [`XLEN-1:0]     target
);

    logic [`XLEN-1:0] base;
    logic [`XLEN-1:0] sum;

    // jalr is register relative, everything else is pc relative
    assign base = (opcode == opJalr) ? rs1Val : pc;
    assign sum  = base + imm;

    // ====================
    // branch condition
    // ====================

    always_comb begin
        case (opcode)
            opBranch: begin
                case (funct3)
                    3'b000:                         taken = zero;          // beq
                    3'b001:                         taken = ~zero;         // bne
                    3'b100, 3'b101, 3'b110, 3'b111: taken = aluResult[0];  // compare kinds
                    default:                        taken = 1'b0;
                endcase
            end
            opJal, opJalr: taken = 1'b1;
            default:       taken = 1'b0;
        endcase
    end

    // ====================
    // transfer target
    // ====================

    always_comb begin
        case (opcode)
            opBranch, opJal: target = sum;
            opJalr:          target = {sum[`XLEN-1:1], 1'b0};
            default:         target = '0;
        endcase
    end

endmodule

// File: src/execControl.sv
`timescale 1ns/1ps
`include "exec_macros.svh"

module execControl import execPkg::*; (
    input  logic             clk,
    input  logic             rstN,
    input  logic             inValid,
    output logic             inReady,
    input  logic             outReady,
    output logic             outValid,
    input  logic [`XLEN-1:0] aluResult,
    input  logic             taken,
    input  logic [`XLEN-1:0] target,
    input  logic             illegalIn,
    output logic [`XLEN-1:0] result,
    output logic             branchTaken,
    output logic [`XLEN-1:0] targetOut,
    output logic             illegal
);

    ctrlStateT state;
    ctrlStateT nextState;
    logic      inFire;
    logic      outFire;

    assign outValid = (state == stFull);
    assign inReady  = (state == stEmpty) || outReady;  // a consume frees the slot this cycle
    assign inFire   = inValid && inReady;
    assign outFire  = outValid && outReady;

    always_comb begin
        nextState = state;
        if (inFire) begin
            nextState = stFull;                        // refill wins over a consume
        end else if (outFire) begin
            nextState = stEmpty;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stEmpty;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (inFire) begin
            result      <= aluResult;
            branchTaken <= taken;
            targetOut   <= target;
            illegal     <= illegalIn;
        end
    end

    // a stalled result must not move or vanish until it is taken
    assertHoldStable: assert property (@(posedge clk) disable iff (!rstN)
        (outValid && !outReady) |=> (outValid && $stable(result) && $stable(branchTaken)
                                     && $stable(targetOut) && $stable(illegal)));

endmodule

// File: src/execUnit.sv
`timescale 1ns/1ps
`include "exec_macros.svh"

module execUnit import execPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    output logic                 inReady,
    input  logic [`OPCODE_W-1:0] opcode,
    input  logic [`FUNCT3_W-1:0] funct3,
    input  logic                 bit30,
    input  logic [`XLEN-1:0]     rs1Val,
    input  logic [`XLEN-1:0]     rs2Val,
    input  logic [`XLEN-1:0]     imm,
    input  logic [`XLEN-1:0]     pc,
    output logic                 outValid,
    input  logic                 outReady,
    output logic [`XLEN-1:0]     result,
    output logic                 branchTaken,
    output logic [`XLEN-1:0]     target,
    output logic                 illegal
);

    aluOpT            aluOp;
    logic             decIllegal;
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluResult;
    logic             aluZero;
    logic             brTaken;
    logic [`XLEN-1:0] brTarget;

    // ====================
    // combinational datapath
    // ====================

    aluDecoder dec0 (
        .opcode  (opcode),
        .funct3  (funct3),
        .bit30   (bit30),
        .aluOp   (aluOp),
        .illegal (decIllegal)
    );

    operandSelect opSel0 (
        .opcode (opcode),
        .rs1Val (rs1Val),
        .rs2Val (rs2Val),
        .imm    (imm),
        .pc     (pc),
        .opA    (opA),
        .opB    (opB)
    );

    aluCore alu0 (
        .aluOp     (aluOp),
        .opA       (opA),
        .opB       (opB),
        .aluResult (aluResult),
        .zero      (aluZero)
    );

    branchUnit br0 (
        .opcode    (opcode),
        .funct3    (funct3),
        .aluResult (aluResult),
        .zero      (aluZero),
        .rs1Val    (rs1Val),
        .imm       (imm),
        .pc        (pc),
        .taken     (brTaken),
        .target    (brTarget)
    );

    // ====================
    // handshake and output register
    // ====================

    execControl ctrl0 (
        .clk         (clk),
        .rstN        (rstN),
        .inValid     (inValid),
        .inReady     (inReady),
        .outReady    (outReady),
        .outValid    (outValid),
        .aluResult   (aluResult),
        .taken       (brTaken),
        .target      (brTarget),
        .illegalIn   (decIllegal),
        .result      (result),
        .branchTaken (branchTaken),
        .targetOut   (target),
        .illegal     (illegal)
    );

endmodule

// File: src/exec_pkg.sv
`include "exec_macros.svh"

package execPkg;

    // ====================
    // alu operations
    // ====================

    typedef enum logic [`ALUOP_W-1:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluSll  = 4'd2,
        aluSlt  = 4'd3,
        aluSltu = 4'd4,
        aluXor  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluOr   = 4'd8,
        aluAnd  = 4'd9,
        aluSge  = 4'd10,     // signed greater or equal, for bge
        aluSgeu = 4'd11      // unsigned greater or equal, for bgeu
    } aluOpT;

    // ====================
    // rv32i major opcodes
    // ====================

    typedef enum logic [`OPCODE_W-1:0] {
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opAuipc  = 7'b0010111,
        opStore  = 7'b0100011,
        opReg    = 7'b0110011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111
    } opcodeT;

    // ====================
    // stage control
    // ====================

    typedef enum logic {
        stEmpty = 1'b0,      // output register holds nothing
        stFull  = 1'b1       // output register holds a result
    } ctrlStateT;

endpackage

// File: src/operandSelect.sv
`timescale 1ns/1ps
`include "exec_macros.svh"

module operandSelect import execPkg::*; (
    input  logic [`OPCODE_W-1:0] opcode,
    input  logic [`XLEN-1:0]     rs1Val,
    input  logic [`XLEN-1:0]     rs2Val,
    input  logic [`XLEN-1:0]     imm,
    input  logic [`XLEN-1:0]     pc,
    output logic [`XLEN-1:0]     opA,
    output logic [`XLEN-1:0]     opB
);

    // ====================
    // operand a
    // ====================

    always_comb begin
        case (opcode)
            opAuipc, opJal, opJalr: opA = pc;
            opLui:                  opA = '0;          // lui result is the immediate alone
            default:                opA = rs1Val;
        endcase
    end

    // ====================
    // operand b
    // ====================

    always_comb begin
        case (opcode)
            opJal, opJalr:   opB = `XLEN'd4;           // the alu forms the link pc+4
            opReg, opBranch: opB = rs2Val;
            default:         opB = imm;
        endcase
    end

endmodule

// File: vlog.f
+incdir+include
src/exec_pkg.sv
src/aluDecoder.sv
src/operandSelect.sv
src/aluCore.sv
src/branchUnit.sv
src/execControl.sv
src/execUnit.sv
bench/execChecker.sv
bench/execUnitTb.sv
